/* Makefile */
# Verilator lint and simulation of the RV32I accelerator testbench

TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = rv_accel_tb
FILELIST   = rv_accel.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run may stop early, the log decides the result
sim: build
	-./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/rv_accel_settings.svh */
// Size settings shared by the accelerator RTL and its testbench
// Include after the timescale line in any file that sizes arrays or data words
`ifndef RV_ACCEL_SETTINGS_SVH
`define RV_ACCEL_SETTINGS_SVH

// ============================================================
// Image SRAM geometry
// ============================================================
// Rows and columns of the image array
`define RV_ACCEL_IMG_H 8
`define RV_ACCEL_IMG_W 8

// ============================================================
// Argmax and data path
// ============================================================
// Entries in the argmax vector buffer
`define RV_ACCEL_VEC_LEN 16
// Width of one stored data word
`define RV_ACCEL_DATA_W 32

`endif

/* rtl/argmax_unit.sv */
// Argmax classifier engine of the accelerator, funct7 0x05
// Buffers a signed vector, then scans one element per cycle after ARG_START
// ARG_STAT and ARG_RD answer through we one cycle after acceptance
`timescale 1ns/1ps
`include "rv_accel_settings.svh"

module argmax_unit (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        valid,
  input  rv_accel_pkg::arg_op_t       op,
  input  logic [31:0]                 rs1_val,
  input  logic [`RV_ACCEL_DATA_W-1:0] rs2_val,
  input  logic [4:0]                  rd_addr,
  output logic                        ready,
  output logic                        we,
  output logic [4:0]                  waddr,
  output logic [`RV_ACCEL_DATA_W-1:0] wdata,
  output logic                        busy,
  output logic                        done
);
  import rv_accel_pkg::*;

  localparam int IDX_W = $clog2(`RV_ACCEL_VEC_LEN);
  localparam logic [IDX_W-1:0] LAST = IDX_W'(`RV_ACCEL_VEC_LEN - 1);

  logic signed [`RV_ACCEL_DATA_W-1:0] vec [`RV_ACCEL_VEC_LEN];
  arg_state_t                         state;
  logic                               fire;
  logic [IDX_W-1:0]                   wr_idx;
  // Scan pointer and running maximum
  logic [IDX_W-1:0]                   cnt;
  logic signed [`RV_ACCEL_DATA_W-1:0] best_val;
  logic [IDX_W-1:0]                   best_idx;
  logic                               take;
  logic [IDX_W-1:0]                   nxt_idx;
  // Index of the last completed scan
  logic [IDX_W-1:0]                   res_idx;

  assign busy = (state == ARG_SCAN);
  assign done = (state == ARG_DONE);

  // Writes and restarts wait for the scan, status reads never stall
  assign ready = !(busy && ((op == ARG_WR) || (op == ARG_START)));
  assign fire  = valid && ready;

  // Index wraps modulo the vector length
  assign wr_idx = IDX_W'(rs1_val[7:0] % `RV_ACCEL_VEC_LEN);

  // Strict compare so a tie keeps the lower index
  assign take    = (cnt == '0) || (vec[cnt] > best_val);
  assign nxt_idx = take ? cnt : best_idx;

  // ============================================================
  // Vector buffer
  // ============================================================
  always_ff @(posedge clk) begin
    if (fire && (op == ARG_WR)) begin
      vec[wr_idx] <= rs2_val;
    end
  end

  // ============================================================
  // Search FSM
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ARG_IDLE;
      cnt     <= '0;
      res_idx <= '0;
    end else begin
      case (state)
        ARG_SCAN: begin
          // One element per cycle, VEC_LEN cycles in total
          cnt <= cnt + 1'b1;
          if (cnt == LAST) begin
            state   <= ARG_DONE;
            res_idx <= nxt_idx;
          end
        end
        default: begin
          // Idle and done both accept a new start
          if (fire && (op == ARG_START)) begin
            state <= ARG_SCAN;
            cnt   <= '0;
          end
        end
      endcase
    end
  end

  // Running maximum
  always_ff @(posedge clk) begin
    if (busy) begin
      if (take) begin
        best_val <= vec[cnt];
      end
      best_idx <= nxt_idx;
    end
  end

  // ============================================================
  // Response
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      we <= 1'b0;
    end else begin
      we <= fire && ((op == ARG_STAT) || (op == ARG_RD));
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      waddr <= rd_addr;
      if (op == ARG_STAT) begin
        // Status word is {busy, done}
        wdata <= {{(`RV_ACCEL_DATA_W-2){1'b0}}, busy, done};
      end else begin
        wdata <= {{(`RV_ACCEL_DATA_W-IDX_W){1'b0}}, res_idx};
      end
    end
  end

endmodule

/* rtl/img_sram_if.sv */
// Image SRAM engine of the accelerator, funct7 0x06
// Handles IM_WR, IM_RD and IM_STAT; always ready
// Reads and status return through we one cycle after acceptance
`timescale 1ns/1ps
`include "rv_accel_settings.svh"

module img_sram_if (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        valid,
  input  rv_accel_pkg::img_op_t       op,
  input  logic [31:0]                 rs1_val,
  input  logic [`RV_ACCEL_DATA_W-1:0] rs2_val,
  input  logic [4:0]                  rd_addr,
  output logic                        ready,
  output logic                        we,
  output logic [4:0]                  waddr,
  output logic [`RV_ACCEL_DATA_W-1:0] wdata,
  output logic                        rvalid
);
  import rv_accel_pkg::*;

  localparam int ROW_W = $clog2(`RV_ACCEL_IMG_H);
  localparam int COL_W = $clog2(`RV_ACCEL_IMG_W);

  logic [`RV_ACCEL_DATA_W-1:0] mem [`RV_ACCEL_IMG_H][`RV_ACCEL_IMG_W];
  logic [7:0]                  row;
  logic [7:0]                  col;
  logic                        in_range;
  logic                        do_wr;
  logic                        do_rd;
  logic                        do_stat;
  // Sticky status flags
  logic                        wr_seen;
  logic                        rd_ok;
  logic [`RV_ACCEL_DATA_W-1:0] rd_word;
  logic [`RV_ACCEL_DATA_W-1:0] stat_word;

  // ============================================================
  // Operand decode
  // ============================================================
  // Row in rs1 bits 15..8, column in bits 7..0
  assign row      = rs1_val[15:8];
  assign col      = rs1_val[7:0];
  assign in_range = (row < `RV_ACCEL_IMG_H) && (col < `RV_ACCEL_IMG_W);

  // No back-pressure from this engine
  assign ready = 1'b1;

  assign do_wr   = valid && (op == IM_WR);
  assign do_rd   = valid && (op == IM_RD);
  assign do_stat = valid && (op == IM_STAT);

  // Out of range reads give zero
  assign rd_word = in_range ? mem[row[ROW_W-1:0]][col[COL_W-1:0]] : '0;

  // Status word is {busy, done, rvalid}, busy never set here
  assign stat_word = {{(`RV_ACCEL_DATA_W-3){1'b0}}, 1'b0, wr_seen, rd_ok};

  // ============================================================
  // Storage
  // ============================================================
  always_ff @(posedge clk) begin
    // Writes outside the array are dropped
    if (do_wr && in_range) begin
      mem[row[ROW_W-1:0]][col[COL_W-1:0]] <= rs2_val;
    end
  end

  // ============================================================
  // Control and response
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      we      <= 1'b0;
      rvalid  <= 1'b0;
      wr_seen <= 1'b0;
      rd_ok   <= 1'b0;
    end else begin
      // One-cycle writeback pulse for reads and status
      we     <= do_rd || do_stat;
      rvalid <= do_rd && in_range;
      // Done means a write actually landed in the array
      if (do_wr && in_range) begin
        wr_seen <= 1'b1;
      end
      // Tracks only the most recent IM_RD
      if (do_rd) begin
        rd_ok <= in_range;
      end
    end
  end

  // Response payload
  always_ff @(posedge clk) begin
    if (do_rd || do_stat) begin
      waddr <= rd_addr;
      wdata <= do_stat ? stat_word : rd_word;
    end
  end

endmodule

/* rtl/rv_accel_pkg.sv */
// Shared types for the RV32I custom-instruction accelerator
// Instruction field encodings, route select and argmax FSM states
package rv_accel_pkg;

  // Major opcode of the custom instructions
  typedef enum logic [6:0] {
    OPC_RTYPE = 7'h33
  } opcode_t;

  // funct7 picks the engine
  typedef enum logic [6:0] {
    F7_ARG = 7'h05,
    F7_IMG = 7'h06
  } unit_t;

  // funct3 for the image SRAM engine
  typedef enum logic [2:0] {
    IM_WR   = 3'b000,
    IM_RD   = 3'b001,
    IM_STAT = 3'b010
  } img_op_t;

  // funct3 for the argmax engine
  typedef enum logic [2:0] {
    ARG_WR    = 3'b000,
    ARG_START = 3'b001,
    ARG_STAT  = 3'b010,
    ARG_RD    = 3'b011
  } arg_op_t;

  // Engine that owns the instruction in flight
  typedef enum logic [1:0] {
    SEL_NONE = 2'd0,
    SEL_IMG  = 2'd1,
    SEL_ARG  = 2'd2
  } sel_t;

  // Argmax search FSM
  typedef enum logic [1:0] {
    ARG_IDLE = 2'd0,
    ARG_SCAN = 2'd1,
    ARG_DONE = 2'd2
  } arg_state_t;

endpackage

/* rtl/rv_accel_top.sv */
// Top level of the RV32I custom-instruction accelerator
// Decodes R-type instructions and routes them to the image or argmax engine
// One instruction in flight; writeback returns one cycle after acceptance
`timescale 1ns/1ps
`include "rv_accel_settings.svh"

module rv_accel_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        instr_valid,
  input  logic [31:0]                 instr,
  input  logic [31:0]                 rs1_val,
  input  logic [31:0]                 rs2_val,
  input  logic [4:0]                  rd_addr,
  output logic                        instr_ready,
  output logic                        rd_we,
  output logic [4:0]                  rd_waddr,
  output logic [`RV_ACCEL_DATA_W-1:0] rd_wdata,
  output logic                        accel_busy,
  output logic                        accel_done,
  output logic                        accel_C_valid
);
  import rv_accel_pkg::*;

  logic [6:0]                  opcode;
  logic [6:0]                  funct7;
  logic [2:0]                  funct3;
  img_op_t                     img_op;
  arg_op_t                     arg_op;
  sel_t                        route;
  // Selection latch, valid only in the cycle after acceptance
  logic                        lat_vld;
  sel_t                        lat_sel;
  logic                        accept;

  // Image engine
  logic                        img_valid;
  logic                        img_ready;
  logic                        img_we;
  logic [4:0]                  img_waddr;
  logic [`RV_ACCEL_DATA_W-1:0] img_wdata;
  logic                        img_rvalid;

  // Argmax engine
  logic                        arg_valid;
  logic                        arg_ready;
  logic                        arg_we;
  logic [4:0]                  arg_waddr;
  logic [`RV_ACCEL_DATA_W-1:0] arg_wdata;
  logic                        arg_busy;
  logic                        arg_done;

  // ============================================================
  // Decode
  // ============================================================
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign img_op = img_op_t'(funct3);
  assign arg_op = arg_op_t'(funct3);

  always_comb begin
    route = SEL_NONE;
    if (opcode == OPC_RTYPE) begin
      case (funct7)
        F7_IMG:  route = SEL_IMG;
        F7_ARG:  route = SEL_ARG;
        // Omitted engines fall through and are dropped
        default: route = SEL_NONE;
      endcase
    end
  end

  // Blocked while a response is pending, else the target engine decides
  always_comb begin
    case (route)
      SEL_IMG: instr_ready = !lat_vld && img_ready;
      SEL_ARG: instr_ready = !lat_vld && arg_ready;
      default: instr_ready = !lat_vld;
    endcase
  end

  assign accept    = instr_valid && instr_ready;
  assign img_valid = instr_valid && !lat_vld && (route == SEL_IMG);
  assign arg_valid = instr_valid && !lat_vld && (route == SEL_ARG);

  // ============================================================
  // Engines
  // ============================================================
  img_sram_if img_sram_if_inst (
    .clk     (clk),
    .rst     (rst),
    .valid   (img_valid),
    .op      (img_op),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .rd_addr (rd_addr),
    .ready   (img_ready),
    .we      (img_we),
    .waddr   (img_waddr),
    .wdata   (img_wdata),
    .rvalid  (img_rvalid)
  );

  argmax_unit argmax_unit_inst (
    .clk     (clk),
    .rst     (rst),
    .valid   (arg_valid),
    .op      (arg_op),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .rd_addr (rd_addr),
    .ready   (arg_ready),
    .we      (arg_we),
    .waddr   (arg_waddr),
    .wdata   (arg_wdata),
    .busy    (arg_busy),
    .done    (arg_done)
  );

  // ============================================================
  // Selection latch and writeback mux
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      lat_vld <= 1'b0;
      lat_sel <= SEL_NONE;
    end else begin
      lat_vld <= accept;
      if (accept) begin
        lat_sel <= route;
      end
    end
  end

  // Only the engine that took the instruction may write back
  always_comb begin
    rd_we    = 1'b0;
    rd_waddr = '0;
    rd_wdata = '0;
    if (lat_vld) begin
      case (lat_sel)
        SEL_IMG: begin
          rd_we    = img_we;
          rd_waddr = img_waddr;
          rd_wdata = img_wdata;
        end
        SEL_ARG: begin
          rd_we    = arg_we;
          rd_waddr = arg_waddr;
          rd_wdata = arg_wdata;
        end
        default: rd_we = 1'b0;
      endcase
    end
  end

  // Status merge
  assign accel_busy    = arg_busy;
  assign accel_done    = arg_done;
  assign accel_C_valid = img_rvalid;

endmodule

/* rv_accel.f */
+incdir+include
rtl/rv_accel_pkg.sv
rtl/img_sram_if.sv
rtl/argmax_unit.sv
rtl/rv_accel_top.sv
tests/rv_accel_chk.sv
tests/rv_accel_tb.sv

/* tests/rv_accel_chk.sv */
// Concurrent protocol checks for the accelerator top level
// Attached to rv_accel_top by a bind in the testbench
`timescale 1ns/1ps

module rv_accel_chk (
  input logic        clk,
  input logic        rst,
  input logic        instr_valid,
  input logic [31:0] instr,
  input logic        instr_ready,
  input logic        rd_we,
  input logic        accel_busy,
  input logic        accel_done
);
  import rv_accel_pkg::*;

  logic accept;
  logic reads;
  // Set once any assertion below fails
  logic assert_fail = 1'b0;

  assign accept = instr_valid && instr_ready;

  // Instructions that owe the core a writeback
  always_comb begin
    reads = 1'b0;
    if (instr[6:0] == OPC_RTYPE) begin
      if (instr[31:25] == F7_IMG) begin
        reads = (instr[14:12] == IM_RD) || (instr[14:12] == IM_STAT);
      end else if (instr[31:25] == F7_ARG) begin
        reads = (instr[14:12] == ARG_STAT) || (instr[14:12] == ARG_RD);
      end
    end
  end

  // ============================================================
  // Writeback timing
  // ============================================================
  wb_after_read: assert property (@(posedge clk) disable iff (rst)
    (accept && reads) |=> rd_we)
  else begin
    assert_fail = 1'b1;
    $error("rd_we missing one cycle after a reading instruction");
  end

  wb_only_after_read: assert property (@(posedge clk) disable iff (rst)
    rd_we |-> $past(accept && reads))
  else begin
    assert_fail = 1'b1;
    $error("rd_we without a reading instruction one cycle earlier");
  end

  // ============================================================
  // Flow control and status
  // ============================================================
  one_in_flight: assert property (@(posedge clk) disable iff (rst)
    accept |=> !instr_ready)
  else begin
    assert_fail = 1'b1;
    $error("instr_ready high in the cycle after an acceptance");
  end

  busy_done_excl: assert property (@(posedge clk) disable iff (rst)
    !(accel_busy && accel_done))
  else begin
    assert_fail = 1'b1;
    $error("accel_busy and accel_done high together");
  end

endmodule

/* tests/rv_accel_tb.sv */
// Testbench for the RV32I custom-instruction accelerator
// Issues R-type instructions, models both engines and checks every writeback in order
`timescale 1ns/1ps
`include "rv_accel_settings.svh"

module rv_accel_tb;
  import rv_accel_pkg::*;

  localparam int DW        = `RV_ACCEL_DATA_W;
  localparam int VLEN      = `RV_ACCEL_VEC_LEN;
  localparam int IH        = `RV_ACCEL_IMG_H;
  localparam int IW        = `RV_ACCEL_IMG_W;
  localparam int NUM_INSTR = 400;

  logic          clk;
  logic          rst;
  logic          instr_valid;
  logic [31:0]   instr;
  logic [31:0]   rs1_val;
  logic [31:0]   rs2_val;
  logic [4:0]    rd_addr;
  logic          instr_ready;
  logic          rd_we;
  logic [4:0]    rd_waddr;
  logic [DW-1:0] rd_wdata;
  logic          accel_busy;
  logic          accel_done;
  logic          accel_C_valid;

  integer        seed;
  int            cycle;
  int            acc_cycle;
  // Expected writebacks, oldest first
  logic [4:0]    exp_addr [$];
  logic [DW-1:0] exp_data [$];
  logic          exp_stat [$];
  logic          exp_cv   [$];
  // Reference state of both engines
  logic [DW-1:0]        m_img [IH][IW];
  logic                 m_wr_seen;
  logic                 m_rd_ok;
  logic signed [DW-1:0] m_vec [VLEN];
  logic                 m_started;
  int                   m_start_cyc;
  int                   m_pend;
  int                   m_res;

  rv_accel_top rv_accel_top_inst (
    .clk           (clk),
    .rst           (rst),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .rs1_val       (rs1_val),
    .rs2_val       (rs2_val),
    .rd_addr       (rd_addr),
    .instr_ready   (instr_ready),
    .rd_we         (rd_we),
    .rd_waddr      (rd_waddr),
    .rd_wdata      (rd_wdata),
    .accel_busy    (accel_busy),
    .accel_done    (accel_done),
    .accel_C_valid (accel_C_valid)
  );

  bind rv_accel_top rv_accel_chk rv_accel_chk_inst (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_ready (instr_ready),
    .rd_we       (rd_we),
    .accel_busy  (accel_busy),
    .accel_done  (accel_done)
  );

  // 20 ns clock and a cycle count for timing checks
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // ============================================================
  // Failure handling and compare tasks
  // ============================================================
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic check_data(input string name, input logic [DW-1:0] got,
                            input logic [DW-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("Fail at %0t ns: %s got %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_waddr(input string name, input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp)
      abort_run($sformatf("Fail at %0t ns: %s got %0d, expected %0d", $time, name, got, exp));
  endtask

  task automatic check_stat(input string name, input logic [DW-1:0] got,
                            input logic [DW-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("Fail at %0t ns: %s got %b, expected %b", $time, name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("Fail at %0t ns: %s got %b, expected %b", $time, name, got, exp));
  endtask

  // ============================================================
  // Reference models
  // ============================================================
  function automatic logic [DW-1:0] img_read_ref(input int row, input int col);
    if ((row < IH) && (col < IW))
      return m_img[row][col];
    return '0;
  endfunction

  // Bits 2..0 are busy, done and rvalid
  function automatic logic [DW-1:0] img_stat_ref(input logic wr_seen, input logic rd_ok);
    return {{(DW-3){1'b0}}, 1'b0, wr_seen, rd_ok};
  endfunction

  // Signed maximum, lowest index wins a tie
  function automatic int argmax_ref();
    int best;
    best = 0;
    for (int i = 1; i < VLEN; i++) begin
      if (m_vec[i] > m_vec[best])
        best = i;
    end
    return best;
  endfunction

  // Busy for VLEN cycles after the start edge, done from then on
  function automatic logic [DW-1:0] arg_stat_ref(input int since);
    logic busy_b;
    logic done_b;
    busy_b = m_started && (since >= 1) && (since <= VLEN);
    done_b = m_started && (since > VLEN);
    return {{(DW-2){1'b0}}, busy_b, done_b};
  endfunction

  // ============================================================
  // Instruction issue
  // ============================================================
  task automatic issue(input logic [6:0] f7, input logic [2:0] f3, input logic [6:0] opc,
                       input logic [31:0] a, input logic [31:0] b, input logic [4:0] rd);
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= {f7, 10'd0, f3, rd, opc};
    rs1_val     <= a;
    rs2_val     <= b;
    rd_addr     <= rd;
    // Held until ready is seen ahead of an edge
    do begin
      @(negedge clk);
    end while (!instr_ready);
    @(posedge clk);
    acc_cycle = cycle;
    instr_valid <= 1'b0;
  endtask

  task automatic expect_wb(input logic [4:0] addr, input logic [DW-1:0] data,
                           input logic is_stat, input logic cv);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_stat.push_back(is_stat);
    exp_cv.push_back(cv);
  endtask

  task automatic img_wr(input int row, input int col, input logic [DW-1:0] d);
    issue(F7_IMG, IM_WR, OPC_RTYPE, {16'd0, row[7:0], col[7:0]}, d, 5'd0);
    if ((row < IH) && (col < IW)) begin
      m_img[row][col] = d;
      m_wr_seen = 1'b1;
    end
  endtask

  task automatic img_rd(input int row, input int col, input logic [4:0] rd);
    logic ok;
    ok = (row < IH) && (col < IW);
    issue(F7_IMG, IM_RD, OPC_RTYPE, {16'd0, row[7:0], col[7:0]}, '0, rd);
    expect_wb(rd, img_read_ref(row, col), 1'b0, ok);
    m_rd_ok = ok;
  endtask

  task automatic img_stat(input logic [4:0] rd);
    issue(F7_IMG, IM_STAT, OPC_RTYPE, '0, '0, rd);
    expect_wb(rd, img_stat_ref(m_wr_seen, m_rd_ok), 1'b1, 1'b0);
  endtask

  task automatic arg_wr(input int idx, input logic [DW-1:0] d);
    issue(F7_ARG, ARG_WR, OPC_RTYPE, idx, d, 5'd0);
    m_vec[idx % VLEN] = d;
  endtask

  task automatic arg_start();
    issue(F7_ARG, ARG_START, OPC_RTYPE, '0, '0, 5'd0);
    // A start is only taken once the previous scan has finished
    if (m_started)
      m_res = m_pend;
    m_pend      = argmax_ref();
    m_started   = 1'b1;
    m_start_cyc = acc_cycle;
  endtask

  task automatic arg_stat(input logic [4:0] rd, output logic done_b);
    logic [DW-1:0] st;
    issue(F7_ARG, ARG_STAT, OPC_RTYPE, '0, '0, rd);
    st = arg_stat_ref(acc_cycle - m_start_cyc);
    expect_wb(rd, st, 1'b1, 1'b0);
    done_b = st[0];
  endtask

  task automatic arg_rd(input logic [4:0] rd);
    issue(F7_ARG, ARG_RD, OPC_RTYPE, '0, '0, rd);
    if (m_started && (acc_cycle - m_start_cyc > VLEN))
      m_res = m_pend;
    expect_wb(rd, DW'(m_res), 1'b0, 1'b0);
  endtask

  // Start, poll status until done, then read the index
  task automatic run_scan(input logic [4:0] rd);
    logic done_b;
    arg_start();
    do begin
      arg_stat(rd, done_b);
    end while (!done_b);
    arg_rd(rd);
  endtask

  // ============================================================
  // Writeback monitor
  // ============================================================
  always @(negedge clk) begin
    if (rv_accel_top_inst.rv_accel_chk_inst.assert_fail) begin
      abort_run("A bound assertion on the DUT failed");
    end else if (!rst && rd_we) begin
      if (exp_addr.size() == 0) begin
        abort_run("The DUT wrote back a register when no writeback was due");
      end else begin
        check_waddr("rd_waddr", rd_waddr, exp_addr.pop_front());
        if (exp_stat.pop_front())
          check_stat("rd_wdata", rd_wdata, exp_data.pop_front());
        else
          check_data("rd_wdata", rd_wdata, exp_data.pop_front());
        check_flag("accel_C_valid", accel_C_valid, exp_cv.pop_front());
      end
    end else if (!rst) begin
      check_flag("accel_C_valid", accel_C_valid, 1'b0);
    end
  end

  // ============================================================
  // Test sequences
  // ============================================================
  task automatic image_tests();
    int order [IH*IW];
    int j;
    int t;
    // Status before any write, and after a dropped write
    img_stat(5'd1);
    img_wr(IH, 0, 32'hdead_beef);
    img_stat(5'd2);
    for (int r = 0; r < IH; r++) begin
      for (int c = 0; c < IW; c++)
        img_wr(r, c, $random(seed));
    end
    img_stat(5'd3);
    // Shuffled read order
    for (int i = 0; i < IH*IW; i++)
      order[i] = i;
    for (int i = IH*IW - 1; i > 0; i--) begin
      j = $unsigned($random(seed)) % (i + 1);
      t = order[i];
      order[i] = order[j];
      order[j] = t;
    end
    for (int i = 0; i < IH*IW; i++)
      img_rd(order[i] / IW, order[i] % IW, 5'($random(seed)));
    img_stat(5'd4);
    // These would alias to (0,3), (0,0) and (7,7) without a range check
    img_wr(8, 3, 32'h1111_1111);
    img_wr(0, 200, 32'h2222_2222);
    img_wr(255, 255, 32'h3333_3333);
    img_rd(0, 3, 5'd5);
    img_rd(0, 0, 5'd6);
    img_rd(7, 7, 5'd7);
    img_rd(9, 1, 5'd8);
    img_stat(5'd9);
    img_rd(2, 2, 5'd10);
    img_stat(5'd11);
  endtask

  task automatic argmax_tests();
    logic [DW-1:0] v;
    // No scan yet, index reads as zero
    arg_rd(5'd12);
    for (int mode = 0; mode < 5; mode++) begin
      for (int i = 0; i < VLEN; i++) begin
        case (mode)
          0: v = $random(seed);
          1: v = $random(seed) | 32'h8000_0000;
          2: v = $random(seed) % 3;
          3: v = -5;
          default: v = i;
        endcase
        // Last vector uses indices past VLEN to hit the wrap
        arg_wr((mode == 4) ? i + VLEN : i, v);
      end
      run_scan(5'(13 + mode));
    end
  endtask

  task automatic busy_tests();
    int n;
    int s;
    logic done_b;
    for (int i = 0; i < VLEN; i++)
      arg_wr(i, $random(seed));
    arg_start();
    n = 0;
    @(negedge clk);
    while (accel_busy) begin
      n++;
      @(negedge clk);
    end
    if (n != VLEN)
      abort_run($sformatf("Fail at %0t ns: accel_busy high for %0d cycles, expected %0d",
                          $time, n, VLEN));
    repeat (4) begin
      check_flag("accel_done", accel_done, 1'b1);
      @(negedge clk);
    end
    // Restart from done, then poke the engine mid-scan
    arg_start();
    s = m_start_cyc;
    arg_stat(5'd20, done_b);
    arg_wr(3, 32'h7fff_ffff);
    if (acc_cycle - s != VLEN + 1)
      abort_run($sformatf("Fail at %0t ns: ARG_WR accepted %0d cycles after start, expected %0d",
                          $time, acc_cycle - s, VLEN + 1));
    arg_rd(5'd21);
    run_scan(5'd22);
  endtask

  task automatic routing_tests();
    int row;
    int col;
    int sel;
    logic done_b;
    logic [6:0] f7;
    for (int k = 0; k < 24; k++) begin
      row = $unsigned($random(seed)) % IH;
      col = $unsigned($random(seed)) % IW;
      sel = $unsigned($random(seed)) % 6;
      case (sel)
        0: img_wr(row, col, $random(seed));
        1: img_rd(row, col, 5'($random(seed)));
        2: arg_stat(5'($random(seed)), done_b);
        3: arg_rd(5'($random(seed)));
        4: begin
          // Unknown funct7 shaped like an image write
          f7 = (k % 2) ? 7'h07 : 7'($unsigned($random(seed)) % 5);
          issue(f7, IM_WR, OPC_RTYPE, {16'd0, row[7:0], col[7:0]}, $random(seed), 5'd1);
          img_rd(row, col, 5'd2);
        end
        default: begin
          // Other opcodes carrying an image write and an argmax start
          issue(F7_IMG, IM_WR, 7'h13, {16'd0, row[7:0], col[7:0]}, $random(seed), 5'd3);
          issue(F7_ARG, ARG_START, 7'h0b, '0, '0, 5'd4);
          img_rd(row, col, 5'd5);
          arg_stat(5'd6, done_b);
        end
      endcase
    end
  endtask

  // ============================================================
  // Main sequence and watchdog
  // ============================================================
  initial begin
    seed        = 54362;
    cycle       = 0;
    acc_cycle   = 0;
    clk         = 1'b0;
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    rs1_val     = '0;
    rs2_val     = '0;
    rd_addr     = '0;
    m_wr_seen   = 1'b0;
    m_rd_ok     = 1'b0;
    m_started   = 1'b0;
    m_start_cyc = 0;
    m_pend      = 0;
    m_res       = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    image_tests();
    argmax_tests();
    busy_tests();
    routing_tests();
    repeat (4) @(posedge clk);
    if (exp_addr.size() != 0) begin
      abort_run("Some expected writebacks never arrived");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

  initial begin
    repeat (NUM_INSTR * 40 + 2000) @(posedge clk);
    abort_run("Timeout: the tests did not finish in the allowed number of cycles");
  end

endmodule
